/* source/periph_pkg.sv */
// Shared definitions for the peripheral side of the CPU bus.
// Holds the address map, field widths, the request and select structs
// and the write data word with its two decodings. Every RTL module
// imports what it needs from here.

package periph_pkg;

    // Bus and field widths
    localparam int bus_addr_width = 24;
    localparam int bus_data_width = 32;
    localparam int operand_width = 16;
    localparam int led_width = 8;
    localparam int flash_lanes = 4;

    // Region field of the byte address
    localparam int region_lsb = 16;
    localparam int region_width = 4;

    localparam logic [region_width-1:0] region_status = 4'd1;
    localparam logic [region_width-1:0] region_dsp = 4'd2;
    localparam logic [region_width-1:0] region_pad = 4'd3;
    localparam logic [region_width-1:0] region_flash = 4'd4;

    // Address bit that steers a dsp write to operand B
    localparam int dsp_operand_b_bit = 2;

    // Request as the bus master presents and holds it
    typedef struct packed {
        logic [bus_addr_width-1:0] address;
        logic [bus_data_width-1:0] write_data;
        logic [bus_data_width/8-1:0] wstrb;
        logic valid;
    } bus_request_t;

    // Flash bit-bang control word
    typedef struct packed {
        logic [15:0] reserved_hi;
        logic active;
        logic [4:0] reserved_lo;
        logic csn;
        logic clk;
        logic [flash_lanes-1:0] out_en;
        logic [flash_lanes-1:0] data;
    } flash_ctrl_t;

    // Plain view, low half carries operands, the LED byte and pad bits
    typedef struct packed {
        logic [bus_data_width-operand_width-1:0] upper;
        logic [operand_width-1:0] operand;
    } generic_word_t;

    typedef union packed {
        flash_ctrl_t flash_ctrl;
        generic_word_t generic;
    } write_word_u;

    // Registered access payload, qualified by the decoder strobe
    typedef struct packed {
        logic status;
        logic dsp;
        logic pad;
        logic flash;
        logic unmapped;
        logic write;
        logic operand_b;
        write_word_u write_data;
    } periph_select_t;

endpackage

/* source/address_decoder.sv */
// Samples a held bus request once and decodes its region.
// Produces a registered one-cycle strobe with the peripheral selects,
// the write flag and the write data; stays busy until valid drops.

module address_decoder (
    input  logic                       vdp_clk,
    input  logic                       vdp_reset,
    input  periph_pkg::bus_request_t   request,
    output logic                       strobe,
    output periph_pkg::periph_select_t select
);
    import periph_pkg::*;

    logic busy;
    logic accept;
    logic [region_width-1:0] region;
    periph_select_t decoded;

    // A request is taken on the first edge that sees it while idle
    assign accept = request.valid && !busy;
    assign region = request.address[region_lsb +: region_width];

    always_comb begin
        decoded.status = (region == region_status);
        decoded.dsp = (region == region_dsp);
        decoded.pad = (region == region_pad);
        decoded.flash = (region == region_flash);
        decoded.unmapped = !(decoded.status || decoded.dsp || decoded.pad || decoded.flash);

        // Any nonzero byte strobe makes it a write
        decoded.write = |request.wstrb;
        decoded.operand_b = request.address[dsp_operand_b_bit];
        decoded.write_data = request.write_data;
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            strobe <= 1'b0;
            busy <= 1'b0;
        end else begin
            strobe <= accept;

            // Held until the master lets go of valid
            if (!request.valid) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            select <= decoded;
        end
    end

endmodule

/* source/control_regs.sv */
// Status LED, gamepad and flash bit-bang control registers.
// Writes land one edge after the decoder strobe and drive the pins
// directly. Also samples pad_data and flash_in for reads.

module control_regs (
    input  logic                                 vdp_clk,
    input  logic                                 vdp_reset,
    input  logic                                 strobe,
    input  periph_pkg::periph_select_t           select,
    input  logic [1:0]                           pad_data,
    input  logic [periph_pkg::flash_lanes-1:0]   flash_in,
    output logic [periph_pkg::led_width-1:0]     led,
    output logic                                 pad_latch,
    output logic                                 pad_clk,
    output logic                                 flash_csn,
    output logic                                 flash_clk,
    output logic [periph_pkg::flash_lanes-1:0]   flash_data_out,
    output logic [periph_pkg::flash_lanes-1:0]   flash_out_en,
    output logic [1:0]                           pad_read,
    output logic [periph_pkg::flash_lanes-1:0]   flash_read
);
    import periph_pkg::*;

    logic [led_width-1:0] status;
    logic [1:0] pad_ctrl;
    flash_ctrl_t flash_ctrl;

    logic status_write;
    logic pad_write;
    logic flash_write;

    assign status_write = strobe && select.write && select.status;
    assign pad_write = strobe && select.write && select.pad;
    assign flash_write = strobe && select.write && select.flash;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= '0;
            pad_ctrl <= '0;
            flash_ctrl <= '0;
        end else begin
            if (status_write) begin
                status <= select.write_data.generic.operand[led_width-1:0];
            end

            // Bit 0 latch, bit 1 clock
            if (pad_write) begin
                pad_ctrl <= select.write_data.generic.operand[1:0];
            end

            if (flash_write) begin
                flash_ctrl <= select.write_data.flash_ctrl;
            end
        end
    end

    // Input samples, read back through the response logic
    always_ff @(posedge vdp_clk) begin
        pad_read <= pad_data;
        flash_read <= flash_in;
    end

    assign led = status;

    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];

    // Pins follow the control word only while active, else idle
    always_comb begin
        if (flash_ctrl.active) begin
            flash_csn = flash_ctrl.csn;
            flash_clk = flash_ctrl.clk;
            flash_out_en = flash_ctrl.out_en;
            flash_data_out = flash_ctrl.data;
        end else begin
            flash_csn = 1'b1;
            flash_clk = 1'b0;
            flash_out_en = '0;
            flash_data_out = '0;
        end
    end

endmodule

/* source/dsp_multiplier.sv */
// Two 16-bit operand registers and their registered signed product.
// Operand B is chosen by an address bit on a dsp write; the product
// follows the operands one edge later.

module dsp_multiplier (
    input  logic                                  vdp_clk,
    input  logic                                  strobe,
    input  periph_pkg::periph_select_t            select,
    output logic [periph_pkg::bus_data_width-1:0] product
);
    import periph_pkg::*;

    logic signed [operand_width-1:0] operand_a;
    logic signed [operand_width-1:0] operand_b;
    logic dsp_write;

    assign dsp_write = strobe && select.write && select.dsp;

    // Operand loads, with the product one edge behind them
    always_ff @(posedge vdp_clk) begin
        if (dsp_write && !select.operand_b) begin
            operand_a <= select.write_data.generic.operand;
        end

        if (dsp_write && select.operand_b) begin
            operand_b <= select.write_data.generic.operand;
        end

        product <= operand_a * operand_b;
    end

endmodule

/* source/bus_response.sv */
// Response side of the peripheral bus.
// Registers mem_ready one edge after the decoder strobe and picks the
// read data for that same cycle, zero outside it.

module bus_response (
    input  logic                                  vdp_clk,
    input  logic                                  vdp_reset,
    input  logic                                  strobe,
    input  periph_pkg::periph_select_t            select,
    input  logic [1:0]                            pad_read,
    input  logic [periph_pkg::flash_lanes-1:0]    flash_read,
    input  logic [periph_pkg::bus_data_width-1:0] product,
    output logic                                  mem_ready,
    output logic [periph_pkg::bus_data_width-1:0] read_data
);
    import periph_pkg::*;

    logic [bus_data_width-1:0] read_mux;

    // Narrow sources are zero-extended
    always_comb begin
        if (select.status || select.unmapped) begin
            read_mux = '0;
        end else if (select.dsp) begin
            read_mux = product;
        end else if (select.pad) begin
            read_mux = bus_data_width'(pad_read);
        end else if (select.flash) begin
            read_mux = bus_data_width'(flash_read);
        end else begin
            read_mux = '0;
        end
    end

    // One ready pulse per decoder strobe
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= strobe;
        end
    end

    always_ff @(posedge vdp_clk) begin
        read_data <= strobe ? read_mux : '0;
    end

endmodule

/* source/periph_bus_top.sv */
// Peripheral bus top level on vdp_clk.
// Takes a held request from the bus master and answers with a one-cycle
// mem_ready two cycles later. Only instances and wiring live here.

module periph_bus_top (
    input  logic                                      vdp_clk,
    input  logic                                      vdp_reset,
    input  periph_pkg::bus_request_t                  request,
    input  logic [1:0]                                pad_data,
    input  logic [periph_pkg::flash_lanes-1:0]        flash_in,
    output logic                                      mem_ready,
    output logic [periph_pkg::bus_data_width-1:0]     read_data,
    output logic [periph_pkg::led_width-1:0]          led,
    output logic                                      pad_latch,
    output logic                                      pad_clk,
    output logic                                      flash_csn,
    output logic                                      flash_clk,
    output logic [periph_pkg::flash_lanes-1:0]        flash_data_out,
    output logic [periph_pkg::flash_lanes-1:0]        flash_out_en
);
    import periph_pkg::*;

    logic strobe;
    periph_select_t select;

    logic [1:0] pad_read;
    logic [flash_lanes-1:0] flash_read;
    logic [bus_data_width-1:0] product;

    // One access in flight at a time
    address_decoder decoder_i (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .request   (request),
        .strobe    (strobe),
        .select    (select)
    );

    control_regs control_regs_i (
        .vdp_clk        (vdp_clk),
        .vdp_reset      (vdp_reset),
        .strobe         (strobe),
        .select         (select),
        .pad_data       (pad_data),
        .flash_in       (flash_in),
        .led            (led),
        .pad_latch      (pad_latch),
        .pad_clk        (pad_clk),
        .flash_csn      (flash_csn),
        .flash_clk      (flash_clk),
        .flash_data_out (flash_data_out),
        .flash_out_en   (flash_out_en),
        .pad_read       (pad_read),
        .flash_read     (flash_read)
    );

    dsp_multiplier dsp_multiplier_i (
        .vdp_clk (vdp_clk),
        .strobe  (strobe),
        .select  (select),
        .product (product)
    );

    // Ready pulse and read data back to the master
    bus_response bus_response_i (
        .vdp_clk    (vdp_clk),
        .vdp_reset  (vdp_reset),
        .strobe     (strobe),
        .select     (select),
        .pad_read   (pad_read),
        .flash_read (flash_read),
        .product    (product),
        .mem_ready  (mem_ready),
        .read_data  (read_data)
    );

endmodule

/* verif/periph_bus_assertions.sv */
// Bound checker for the peripheral bus top level.
// A shadow model follows each accepted request through the two-cycle
// pipeline, and the assertions compare pins and responses against it.

module periph_bus_assertions (
    input logic                                  vdp_clk,
    input logic                                  vdp_reset,
    input periph_pkg::bus_request_t              request,
    input logic [1:0]                            pad_data,
    input logic [periph_pkg::flash_lanes-1:0]    flash_in,
    input logic                                  mem_ready,
    input logic [periph_pkg::bus_data_width-1:0] read_data,
    input logic [periph_pkg::led_width-1:0]      led,
    input logic                                  pad_latch,
    input logic                                  pad_clk,
    input logic                                  flash_csn,
    input logic                                  flash_clk,
    input logic [periph_pkg::flash_lanes-1:0]    flash_data_out,
    input logic [periph_pkg::flash_lanes-1:0]    flash_out_en
);
    timeunit 1ns;
    timeprecision 1ps;

    import periph_pkg::*;

    int failures = 0;

    logic busy_m;
    logic accept_m;
    logic in_flight;
    logic ready_exp;
    bus_request_t req_m;
    write_word_u word_m;
    logic [region_width-1:0] region_m;
    logic [1:0] pad_cap;
    logic [flash_lanes-1:0] flash_cap;
    logic [led_width-1:0] led_m;
    logic [1:0] pad_m;
    flash_ctrl_t flash_m;
    logic signed [operand_width-1:0] op_a_m;
    logic signed [operand_width-1:0] op_b_m;
    logic signed [bus_data_width-1:0] product_m;
    logic [bus_data_width-1:0] read_exp;
    logic [9:0] flash_pins_m;

    assign accept_m = request.valid && !busy_m;
    assign word_m = req_m.write_data;
    assign region_m = req_m.address[region_lsb +: region_width];
    assign product_m = op_a_m * op_b_m;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            busy_m <= 1'b0;
            in_flight <= 1'b0;
            ready_exp <= 1'b0;
            led_m <= '0;
            pad_m <= '0;
            flash_m <= '0;
        end else begin
            // Busy from acceptance until valid drops
            busy_m <= request.valid;
            in_flight <= accept_m;
            ready_exp <= in_flight;
            if (accept_m) begin
                req_m <= request;
                pad_cap <= pad_data;
                flash_cap <= flash_in;
            end
            // Writes land on the edge after acceptance
            if (in_flight && req_m.wstrb != '0) begin
                case (region_m)
                    region_status: led_m <= word_m.generic.operand[led_width-1:0];
                    region_pad: pad_m <= word_m.generic.operand[1:0];
                    region_flash: flash_m <= word_m.flash_ctrl;
                    region_dsp: begin
                        if (req_m.address[dsp_operand_b_bit]) begin
                            op_b_m <= word_m.generic.operand;
                        end else begin
                            op_a_m <= word_m.generic.operand;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (region_m)
            region_dsp: read_exp = product_m;
            region_pad: read_exp = bus_data_width'(pad_cap);
            region_flash: read_exp = bus_data_width'(flash_cap);
            default: read_exp = '0;
        endcase
    end

    // Idle pins whenever the active bit is clear
    assign flash_pins_m = flash_m.active ?
        {flash_m.csn, flash_m.clk, flash_m.out_en, flash_m.data} : 10'h200;

    a_ready: assert property (@(posedge vdp_clk) disable iff (vdp_reset) mem_ready == ready_exp)
        else begin
            failures++;
            $error("MISMATCH at %0t: mem_ready got %b expected %b", $time,
                $sampled(mem_ready), $sampled(ready_exp));
        end

    a_read_data: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        (mem_ready && req_m.wstrb == '0) |-> read_data == read_exp)
        else begin
            failures++;
            $error("MISMATCH at %0t: read_data got %h expected %h", $time,
                $sampled(read_data), $sampled(read_exp));
        end

    a_led: assert property (@(posedge vdp_clk) disable iff (vdp_reset) led == led_m)
        else begin
            failures++;
            $error("MISMATCH at %0t: led got %h expected %h", $time, $sampled(led), $sampled(led_m));
        end

    a_pad: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        {pad_clk, pad_latch} == pad_m)
        else begin
            failures++;
            $error("MISMATCH at %0t: pad_clk/pad_latch got %b expected %b", $time,
                $sampled({pad_clk, pad_latch}), $sampled(pad_m));
        end

    a_flash: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        {flash_csn, flash_clk, flash_out_en, flash_data_out} == flash_pins_m)
        else begin
            failures++;
            $error("MISMATCH at %0t: flash pins got %h expected %h", $time,
                $sampled({flash_csn, flash_clk, flash_out_en, flash_data_out}),
                $sampled(flash_pins_m));
        end

endmodule

/* verif/periph_bus_tb.sv */
// Testbench for the peripheral bus top level.
// Runs held bus requests against every region, prints a line per test
// and a closing summary. The bound checker does most of the checking.

module periph_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import periph_pkg::*;

    localparam int max_requests = 40;
    localparam int cycle_limit = max_requests * 4 + 100;
    localparam logic [region_width-1:0] unmapped_region = 4'hf;
    // csn high, everything else low
    localparam logic [9:0] flash_idle_pins = 10'h200;

    logic vdp_clk = 1'b0;
    logic vdp_reset = 1'b1;
    bus_request_t request;
    logic [1:0] pad_data;
    logic [flash_lanes-1:0] flash_in;
    logic mem_ready;
    logic [bus_data_width-1:0] read_data;
    logic [led_width-1:0] led;
    logic pad_latch;
    logic pad_clk;
    logic flash_csn;
    logic flash_clk;
    logic [flash_lanes-1:0] flash_data_out;
    logic [flash_lanes-1:0] flash_out_en;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_start_errors = 0;
    int cycles = 0;
    logic [31:0] rng_state = 32'h2fca64ae;

    bind periph_bus_top periph_bus_assertions assertions_i (.*);

    periph_bus_top dut_i (.*);

    always #50 vdp_clk = ~vdp_clk;

    always @(posedge vdp_clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run passed %0d cycles without finishing", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] random_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [bus_addr_width-1:0] region_address(
        input logic [region_width-1:0] region,
        input logic [15:0] offset
    );
        return bus_addr_width'({region, offset});
    endfunction

    function automatic int error_total();
        return errors + dut_i.assertions_i.failures;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // One held request, valid dropped once mem_ready is seen
    task automatic bus_access(
        input logic [bus_addr_width-1:0] address,
        input logic [bus_data_width-1:0] data,
        input logic [3:0] wstrb,
        input int hold,
        output logic [bus_data_width-1:0] rdata,
        output int latency
    );
        @(negedge vdp_clk);
        request.address = address;
        request.write_data = data;
        request.wstrb = wstrb;
        request.valid = 1'b1;
        latency = 0;
        do begin
            @(negedge vdp_clk);
            latency++;
        end while (!mem_ready);
        rdata = read_data;
        repeat (hold) begin
            @(negedge vdp_clk);
            if (mem_ready) begin
                errors++;
                $display("Second mem_ready pulse at %0t while valid was held", $time);
            end
        end
        request.valid = 1'b0;
    endtask

    task automatic write_reg(input logic [bus_addr_width-1:0] address, input logic [31:0] data);
        logic [31:0] unused_data;
        int unused_latency;
        bus_access(address, data, 4'hf, 0, unused_data, unused_latency);
    endtask

    task automatic read_reg(input logic [bus_addr_width-1:0] address, output logic [31:0] data);
        int latency;
        bus_access(address, 32'h0, 4'h0, 0, data, latency);
    endtask

    task automatic finish_test(input string name);
        int test_errors;
        // Let the checker see the last response
        repeat (2) @(negedge vdp_clk);
        test_errors = error_total() - test_start_errors;
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, test_errors);
        end
        test_start_errors = error_total();
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] value;
        logic [31:0] value_b;
        logic signed [15:0] op_a;
        logic signed [15:0] op_b;
        logic signed [31:0] product;
        logic [9:0] pins_exp;
        int latency;
        write_word_u word;

        request = '0;
        pad_data = '0;
        flash_in = '0;
        repeat (3) @(posedge vdp_clk);
        @(negedge vdp_clk);
        vdp_reset = 1'b0;

        @(negedge vdp_clk);
        check_value("led", 32'(led), 32'h0);
        check_value("mem_ready", 32'(mem_ready), 32'h0);
        check_value("pad_clk/pad_latch", {30'b0, pad_clk, pad_latch}, 32'h0);
        check_value("flash pins", {22'b0, flash_csn, flash_clk, flash_out_en, flash_data_out},
            {22'b0, flash_idle_pins});
        finish_test("reset_state");

        // Second access holds valid past mem_ready
        bus_access(region_address(region_status, 16'h0), 32'h0, 4'h0, 0, rdata, latency);
        check_value("mem_ready latency", latency, 32'd2);
        bus_access(region_address(region_pad, 16'h0), 32'h0, 4'h0, 3, rdata, latency);
        check_value("mem_ready latency", latency, 32'd2);
        finish_test("ready_timing");

        value = random_word();
        write_reg(region_address(region_status, 16'h0), value);
        check_value("led", 32'(led), 32'(value[7:0]));
        read_reg(region_address(region_status, 16'h0), rdata);
        check_value("read_data", rdata, 32'h0);
        read_reg(region_address(unmapped_region, 16'h0), rdata);
        check_value("read_data", rdata, 32'h0);
        write_reg(region_address(unmapped_region, 16'h0), random_word());
        check_value("led", 32'(led), 32'(value[7:0]));
        finish_test("status_register");

        repeat (3) begin
            value = random_word();
            value_b = random_word();
            op_a = value[15:0];
            op_b = value_b[15:0];
            product = op_a * op_b;
            write_reg(region_address(region_dsp, 16'h0), value);
            write_reg(region_address(region_dsp, 16'h4), value_b);
            read_reg(region_address(region_dsp, 16'h0), rdata);
            check_value("read_data", rdata, product);
        end
        finish_test("multiplier");

        repeat (3) begin
            value = random_word();
            write_reg(region_address(region_pad, 16'h0), value);
            check_value("pad_clk/pad_latch", {30'b0, pad_clk, pad_latch}, {30'b0, value[1:0]});
            pad_data = value[9:8];
            read_reg(region_address(region_pad, 16'h0), rdata);
            check_value("read_data", rdata, {30'b0, pad_data});
        end
        finish_test("gamepad");

        // Active first, then cleared
        for (int i = 0; i < 2; i++) begin
            value = random_word();
            word = value;
            word.flash_ctrl.active = (i == 0);
            flash_in = value[19:16];
            write_reg(region_address(region_flash, 16'h0), word);
            if (word.flash_ctrl.active) begin
                pins_exp = {word.flash_ctrl.csn, word.flash_ctrl.clk,
                    word.flash_ctrl.out_en, word.flash_ctrl.data};
            end else begin
                pins_exp = flash_idle_pins;
            end
            check_value("flash pins", {22'b0, flash_csn, flash_clk, flash_out_en, flash_data_out},
                {22'b0, pins_exp});
            read_reg(region_address(region_flash, 16'h0), rdata);
            check_value("read_data", rdata, {28'b0, flash_in});
        end
        finish_test("flash_control");

        $display("%0d tests run, %0d failed, %0d errors in total",
            tests_run, tests_failed, error_total());
        if (error_total() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* all.f */
source/periph_pkg.sv
source/address_decoder.sv
source/control_regs.sv
source/dsp_multiplier.sv
source/bus_response.sv
source/periph_bus_top.sv
verif/periph_bus_assertions.sv
verif/periph_bus_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the peripheral bus testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_bus_tb -f all.f -o periph_bus_sim

# Keep running past assertion errors so the summary is printed
./obj_dir/periph_bus_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi
